/* design/exu_pkg.sv */
package exu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    parameter int xlen       = 32;                // Data and PC width
    parameter int reg_addr_w = 5;                 // x0..x31

    parameter int bypass_depth_default = 3;       // Writers kept for forwarding

    //////////////////////////////////////////////////////////////////////
    // ALU operations
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_slt    = 4'd8,
        alu_sltu   = 4'd9,
        alu_pass_b = 4'd10                        // lui
    } alu_op_t;

    //////////////////////////////////////////////////////////////////////
    // Branch compare operations
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        cmp_eq  = 3'd0,
        cmp_ne  = 3'd1,
        cmp_lt  = 3'd2,
        cmp_ge  = 3'd3,
        cmp_ltu = 3'd4,
        cmp_geu = 3'd5
    } cmp_op_t;

endpackage

/* design/exu_operand_fwd.sv */
`timescale 1ns/1ps

module exu_operand_fwd #(
    parameter int bypass_depth = exu_pkg::bypass_depth_default
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           idu_valid,
    input  logic                           lsu_ready,
    input  logic [exu_pkg::reg_addr_w-1:0] rs1,
    input  logic [exu_pkg::reg_addr_w-1:0] rs2,
    input  logic [exu_pkg::xlen-1:0]       rs1_data,
    input  logic [exu_pkg::xlen-1:0]       rs2_data,
    input  logic [exu_pkg::xlen-1:0]       wb_data,
    input  logic [exu_pkg::reg_addr_w-1:0] rd,
    input  logic                           gpr_we,
    input  logic                           is_load,
    input  logic                           load_data_valid,
    input  logic [exu_pkg::xlen-1:0]       load_data,
    input  logic                           redirect_valid,
    output logic [exu_pkg::xlen-1:0]       src1,
    output logic [exu_pkg::xlen-1:0]       src2,
    output logic                           load_wait,
    output logic                           issue
);
    import exu_pkg::*;

    logic [reg_addr_w-1:0] byp_rd    [bypass_depth];
    logic [xlen-1:0]       byp_data  [bypass_depth];
    logic                  byp_valid [bypass_depth];
    logic                  byp_pend  [bypass_depth];   // Load data still outstanding
    logic [xlen-1:0]       fill_data [bypass_depth];
    logic                  fill_pend [bypass_depth];
    logic [xlen:0]         sel1;
    logic [xlen:0]         sel2;
    logic                  push;

    // Returns {pending, data} of the youngest writer of rs, else the regfile value
    function automatic logic [xlen:0] pick(input logic [reg_addr_w-1:0] rs,
                                           input logic [xlen-1:0]       rf_data);
        logic [xlen:0] r;
        r = {1'b0, rf_data};
        for (int i = bypass_depth - 1; i >= 0; i--) begin
            if (byp_valid[i] && (byp_rd[i] == rs) && (rs != '0)) begin
                r = {byp_pend[i], byp_data[i]};
            end
        end
        return r;
    endfunction

    always_comb begin
        sel1 = pick(rs1, rs1_data);
        sel2 = pick(rs2, rs2_data);
    end

    assign src1      = sel1[xlen-1:0];
    assign src2      = sel2[xlen-1:0];
    assign load_wait = sel1[xlen] | sel2[xlen];
    assign issue     = idu_valid & lsu_ready & ~load_wait & ~redirect_valid;
    assign push      = issue & gpr_we;

    // Load return lands in whichever entry is still pending
    always_comb begin
        for (int i = 0; i < bypass_depth; i++) begin
            fill_data[i] = (load_data_valid && byp_pend[i]) ? load_data : byp_data[i];
            fill_pend[i] = byp_pend[i] & ~load_data_valid;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bypass_depth; i++) begin
                byp_rd[i]    <= '0;
                byp_data[i]  <= '0;
                byp_valid[i] <= 1'b0;
                byp_pend[i]  <= 1'b0;
            end
        end else begin
            for (int i = 0; i < bypass_depth; i++) begin
                byp_data[i] <= fill_data[i];
                byp_pend[i] <= fill_pend[i];
            end
            if (push) begin
                for (int i = bypass_depth - 1; i > 0; i--) begin
                    byp_rd[i]    <= byp_rd[i-1];
                    byp_data[i]  <= fill_data[i-1];
                    byp_valid[i] <= byp_valid[i-1];
                    byp_pend[i]  <= fill_pend[i-1];
                end
                byp_rd[0]    <= rd;
                byp_data[0]  <= is_load ? '0 : wb_data;   // Filled later for loads
                byp_valid[0] <= 1'b1;
                byp_pend[0]  <= is_load;
            end
        end
    end

endmodule

/* design/exu_alu.sv */
`timescale 1ns/1ps

module exu_alu (
    input  exu_pkg::alu_op_t           alu_op,
    input  exu_pkg::cmp_op_t           cmp_op,
    input  logic [exu_pkg::xlen-1:0]   a,
    input  logic [exu_pkg::xlen-1:0]   b,
    input  logic [exu_pkg::xlen-1:0]   cmp_a,
    input  logic [exu_pkg::xlen-1:0]   cmp_b,
    output logic [exu_pkg::xlen-1:0]   alu_result,
    output logic                       taken
);
    import exu_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];

    //////////////////////////////////////////////////////////////////////
    // Arithmetic and logic
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (alu_op)
            alu_add:    alu_result = a + b;
            alu_sub:    alu_result = a - b;
            alu_and:    alu_result = a & b;
            alu_or:     alu_result = a | b;
            alu_xor:    alu_result = a ^ b;
            alu_sll:    alu_result = a << shamt;
            alu_srl:    alu_result = a >> shamt;
            alu_sra:    alu_result = $signed(a) >>> shamt;
            alu_slt: begin
                alu_result = '0;
                alu_result[0] = $signed(a) < $signed(b);
            end
            alu_sltu: begin
                alu_result = '0;
                alu_result[0] = a < b;
            end
            alu_pass_b: alu_result = b;
            default:    alu_result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Branch compare
    //////////////////////////////////////////////////////////////////////

    // Runs on the raw operands while the adder forms the target
    assign lt_s = $signed(cmp_a) < $signed(cmp_b);
    assign lt_u = cmp_a < cmp_b;

    always_comb begin
        case (cmp_op)
            cmp_eq:  taken = (cmp_a == cmp_b);
            cmp_ne:  taken = (cmp_a != cmp_b);
            cmp_lt:  taken = lt_s;
            cmp_ge:  taken = ~lt_s;
            cmp_ltu: taken = lt_u;
            cmp_geu: taken = ~lt_u;
            default: taken = 1'b0;
        endcase
    end

endmodule

/* design/exu_redirect.sv */
`timescale 1ns/1ps

module exu_redirect (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue,
    input  logic [exu_pkg::xlen-1:0] pc,
    input  logic [exu_pkg::xlen-1:0] alu_result,
    input  logic                     is_jump,
    input  logic                     is_branch,
    input  logic                     taken,
    input  logic                     pc_update,
    output logic                     redirect_valid,
    output logic [exu_pkg::xlen-1:0] redirect_pc
);
    import exu_pkg::*;

    logic [xlen-1:0] target;
    logic [xlen-1:0] seq_pc;
    logic            change;

    // pc+imm for branches and jal, rs1+imm for jalr
    assign target = {alu_result[xlen-1:1], 1'b0};
    assign seq_pc = pc + xlen'(4);

    // A taken branch to the next PC needs no redirect
    assign change = is_jump | (is_branch & taken & (target != seq_pc));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end else if (issue && change) begin
            redirect_valid <= 1'b1;
            redirect_pc    <= target;
        end else if (pc_update) begin
            redirect_valid <= 1'b0;                 // Fetch took the new PC
        end
    end

endmodule

/* design/exu_result_reg.sv */
`timescale 1ns/1ps

module exu_result_reg (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           lsu_ready,
    input  logic                           issue,
    input  logic [exu_pkg::xlen-1:0]       result,
    input  logic [exu_pkg::xlen-1:0]       store_data,
    input  logic [exu_pkg::reg_addr_w-1:0] rd,
    input  logic                           gpr_we,
    input  logic                           is_load,
    input  logic                           is_store,
    output logic                           exu_valid,
    output logic [exu_pkg::xlen-1:0]       res_out,
    output logic [exu_pkg::xlen-1:0]       store_data_out,
    output logic [exu_pkg::reg_addr_w-1:0] rd_out,
    output logic                           gpr_we_out,
    output logic                           is_load_out,
    output logic                           is_store_out
);

    //////////////////////////////////////////////////////////////////////
    // Stage register towards the load/store unit
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exu_valid      <= 1'b0;
            res_out        <= '0;
            store_data_out <= '0;
            rd_out         <= '0;
            gpr_we_out     <= 1'b0;
            is_load_out    <= 1'b0;
            is_store_out   <= 1'b0;
        end else if (lsu_ready) begin
            exu_valid <= issue;                     // Bubble when nothing issued
            if (issue) begin
                res_out        <= result;
                store_data_out <= store_data;
                rd_out         <= rd;
                gpr_we_out     <= gpr_we;
                is_load_out    <= is_load;
                is_store_out   <= is_store;
            end
        end
    end

endmodule

/* design/exu_top.sv */
`timescale 1ns/1ps

module exu_top #(
    parameter int bypass_depth = exu_pkg::bypass_depth_default
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           idu_valid,
    output logic                           exu_ready,
    input  logic [exu_pkg::xlen-1:0]       pc,
    input  logic [exu_pkg::xlen-1:0]       imm,
    input  logic [exu_pkg::reg_addr_w-1:0] rs1,
    input  logic [exu_pkg::reg_addr_w-1:0] rs2,
    input  logic [exu_pkg::xlen-1:0]       rs1_data,
    input  logic [exu_pkg::xlen-1:0]       rs2_data,
    input  logic [exu_pkg::reg_addr_w-1:0] rd,
    input  logic                           gpr_we,
    input  logic                           is_load,
    input  logic                           is_store,
    input  exu_pkg::alu_op_t               alu_op,
    input  exu_pkg::cmp_op_t               cmp_op,
    input  logic                           src1_is_pc,
    input  logic                           src2_is_imm,
    input  logic                           is_jump,
    input  logic                           is_branch,
    input  logic                           lsu_ready,
    output logic                           exu_valid,
    output logic [exu_pkg::xlen-1:0]       res_out,
    output logic [exu_pkg::xlen-1:0]       store_data_out,
    output logic [exu_pkg::reg_addr_w-1:0] rd_out,
    output logic                           gpr_we_out,
    output logic                           is_load_out,
    output logic                           is_store_out,
    input  logic                           load_data_valid,
    input  logic [exu_pkg::xlen-1:0]       load_data,
    input  logic                           pc_update,
    output logic                           redirect_valid,
    output logic [exu_pkg::xlen-1:0]       redirect_pc
);
    import exu_pkg::*;

    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] result;
    logic            taken;
    logic            load_wait;
    logic            issue;

    assign exu_ready = lsu_ready & ~load_wait;

    assign alu_a  = src1_is_pc  ? pc  : src1;
    assign alu_b  = src2_is_imm ? imm : src2;
    assign result = is_jump ? pc + xlen'(4) : alu_result;   // Link address

    exu_operand_fwd #(
        .bypass_depth    (bypass_depth)
    ) u_fwd (
        .clk             (clk),
        .rst             (rst),
        .idu_valid       (idu_valid),
        .lsu_ready       (lsu_ready),
        .rs1             (rs1),
        .rs2             (rs2),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .wb_data         (result),
        .rd              (rd),
        .gpr_we          (gpr_we),
        .is_load         (is_load),
        .load_data_valid (load_data_valid),
        .load_data       (load_data),
        .redirect_valid  (redirect_valid),
        .src1            (src1),
        .src2            (src2),
        .load_wait       (load_wait),
        .issue           (issue)
    );

    exu_alu u_alu (
        .alu_op     (alu_op),
        .cmp_op     (cmp_op),
        .a          (alu_a),
        .b          (alu_b),
        .cmp_a      (src1),
        .cmp_b      (src2),
        .alu_result (alu_result),
        .taken      (taken)
    );

    exu_redirect u_redir (
        .clk            (clk),
        .rst            (rst),
        .issue          (issue),
        .pc             (pc),
        .alu_result     (alu_result),
        .is_jump        (is_jump),
        .is_branch      (is_branch),
        .taken          (taken),
        .pc_update      (pc_update),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    exu_result_reg u_res (
        .clk            (clk),
        .rst            (rst),
        .lsu_ready      (lsu_ready),
        .issue          (issue),
        .result         (result),
        .store_data     (src2),
        .rd             (rd),
        .gpr_we         (gpr_we),
        .is_load        (is_load),
        .is_store       (is_store),
        .exu_valid      (exu_valid),
        .res_out        (res_out),
        .store_data_out (store_data_out),
        .rd_out         (rd_out),
        .gpr_we_out     (gpr_we_out),
        .is_load_out    (is_load_out),
        .is_store_out   (is_store_out)
    );

endmodule

/* test/exu_checker.sv */
`timescale 1ns/1ps

module exu_checker #(
    parameter int bypass_depth = exu_pkg::bypass_depth_default
) (
    input logic                           clk, rst, idu_valid, exu_ready, lsu_ready,
    input logic [exu_pkg::xlen-1:0]       pc, imm, rs1_data, rs2_data, load_data,
    input logic [exu_pkg::xlen-1:0]       res_out, store_data_out, redirect_pc,
    input logic [exu_pkg::reg_addr_w-1:0] rs1, rs2, rd, rd_out,
    input logic                           gpr_we, is_load, is_store, src1_is_pc, src2_is_imm,
    input logic                           is_jump, is_branch, exu_valid, gpr_we_out,
    input logic                           is_load_out, is_store_out, load_data_valid,
    input logic                           pc_update, redirect_valid,
    input exu_pkg::alu_op_t               alu_op,
    input exu_pkg::cmp_op_t               cmp_op
);
    import exu_pkg::*;

    int errors = 0;
    int checked = 0;
    logic [reg_addr_w-1:0] m_rd    [bypass_depth];   // Index 0 is the youngest writer
    logic [xlen-1:0]       m_data  [bypass_depth];
    logic                  m_valid [bypass_depth];
    logic                  m_pend  [bypass_depth];
    logic                  e_valid, e_we, e_ld, e_st, e_rv;
    logic [xlen-1:0]       e_res, e_sd, e_rpc, op1, op2, res, tgt;
    logic [reg_addr_w-1:0] e_rd;
    logic                  pend1, pend2, redir, issue;

    function automatic void exu_model(input alu_op_t aop, input cmp_op_t cop,
                                      input logic [xlen-1:0] ipc, iimm, s1, s2,
                                      input logic use_pc, use_imm, jump, branch,
                                      output logic [xlen-1:0] result, target,
                                      output logic redirect);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] v;
        logic            cond;
        a = use_pc ? ipc : s1;
        b = use_imm ? iimm : s2;
        case (aop)
            alu_add:  v = a + b;
            alu_sub:  v = a - b;
            alu_and:  v = a & b;
            alu_or:   v = a | b;
            alu_xor:  v = a ^ b;
            alu_sll:  v = a << b[4:0];
            alu_srl:  v = a >> b[4:0];
            alu_sra:  v = $signed(a) >>> b[4:0];
            alu_slt:  v = xlen'($signed(a) < $signed(b));
            alu_sltu: v = xlen'(a < b);
            default:  v = b;                          // lui
        endcase
        case (cop)
            cmp_eq:  cond = (s1 == s2);
            cmp_ne:  cond = (s1 != s2);
            cmp_lt:  cond = $signed(s1) < $signed(s2);
            cmp_ge:  cond = $signed(s1) >= $signed(s2);
            cmp_ltu: cond = s1 < s2;
            default: cond = s1 >= s2;
        endcase
        target   = {v[xlen-1:1], 1'b0};
        result   = jump ? ipc + 4 : v;
        redirect = jump || (branch && cond && target != ipc + 4);
    endfunction

    // {pending, value} seen by one source register
    function automatic logic [xlen:0] resolve(input logic [reg_addr_w-1:0] rs,
                                              input logic [xlen-1:0] rf_value);
        for (int i = 0; i < bypass_depth; i++) begin
            if (m_valid[i] && m_rd[i] == rs && rs != 0) begin
                return {m_pend[i], m_data[i]};
            end
        end
        return {1'b0, rf_value};
    endfunction

    task automatic check_value(input string name, input logic [xlen-1:0] expected, actual);
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            check_value("reset exu_valid", '0, xlen'(exu_valid));
            check_value("reset redirect_valid", '0, xlen'(redirect_valid));
            e_valid = 1'b0;
            e_rv    = 1'b0;
            for (int i = 0; i < bypass_depth; i++) begin
                m_valid[i] = 1'b0;
                m_pend[i]  = 1'b0;
            end
        end else begin
            //////////////////////////////////////////////////////////////////////
            // Outputs against what the last edge should have produced
            //////////////////////////////////////////////////////////////////////
            check_value("exu_valid", xlen'(e_valid), xlen'(exu_valid));
            check_value("redirect_valid", xlen'(e_rv), xlen'(redirect_valid));
            if (e_rv) begin
                check_value("redirect_pc", e_rpc, redirect_pc);
            end
            if (e_valid && exu_valid) begin
                checked++;
                check_value("result", e_res, res_out);
                check_value("store_data", e_sd, store_data_out);
                check_value("rd", xlen'(e_rd), xlen'(rd_out));
                check_value("control", xlen'({e_we, e_ld, e_st}),
                            xlen'({gpr_we_out, is_load_out, is_store_out}));
            end

            //////////////////////////////////////////////////////////////////////
            // This cycle's instruction
            //////////////////////////////////////////////////////////////////////
            {pend1, op1} = resolve(rs1, rs1_data);
            {pend2, op2} = resolve(rs2, rs2_data);
            check_value("exu_ready", xlen'(lsu_ready && !pend1 && !pend2), xlen'(exu_ready));
            issue = idu_valid && lsu_ready && !pend1 && !pend2 && !e_rv;
            exu_model(alu_op, cmp_op, pc, imm, op1, op2, src1_is_pc, src2_is_imm,
                      is_jump, is_branch, res, tgt, redir);

            if (lsu_ready) begin
                e_valid = issue;
                if (issue) begin
                    e_res = res;
                    e_sd  = op2;
                    e_rd  = rd;
                    e_we  = gpr_we;
                    e_ld  = is_load;
                    e_st  = is_store;
                end
            end
            if (issue && redir) begin
                e_rv  = 1'b1;
                e_rpc = tgt;
            end else if (pc_update) begin
                e_rv = 1'b0;
            end

            for (int i = 0; i < bypass_depth; i++) begin
                if (load_data_valid && m_pend[i]) begin
                    m_data[i] = load_data;
                    m_pend[i] = 1'b0;
                end
            end
            if (issue && gpr_we) begin
                for (int i = bypass_depth - 1; i > 0; i--) begin
                    m_rd[i]    = m_rd[i-1];
                    m_data[i]  = m_data[i-1];
                    m_valid[i] = m_valid[i-1];
                    m_pend[i]  = m_pend[i-1];
                end
                m_rd[0]    = rd;
                m_data[0]  = res;
                m_valid[0] = 1'b1;
                m_pend[0]  = is_load;              // Value comes with load_data_valid
            end
        end
    end

endmodule

/* test/exu_tb.sv */
`timescale 1ns/1ps

module exu_tb;
    import exu_pkg::*;

    localparam int depth      = bypass_depth_default;
    localparam int n_instr    = 2000;
    localparam int max_cycles = 12;                  // Per instruction, worst case

    logic                  clk = 1'b0;
    logic                  rst, idu_valid, exu_ready, lsu_ready;
    logic [xlen-1:0]       pc, imm, rs1_data, rs2_data, load_data;
    logic [xlen-1:0]       res_out, store_data_out, redirect_pc;
    logic [reg_addr_w-1:0] rs1, rs2, rd, rd_out;
    logic                  gpr_we, is_load, is_store, src1_is_pc, src2_is_imm;
    logic                  is_jump, is_branch, exu_valid, gpr_we_out;
    logic                  is_load_out, is_store_out, load_data_valid;
    logic                  pc_update, redirect_valid;
    alu_op_t               alu_op;
    cmp_op_t               cmp_op;

    logic [xlen-1:0]       rf [32];                  // Register file seen by decode
    logic                  acc;
    logic                  ld_busy = 1'b0;
    logic                  ld_fire = 1'b0;
    logic                  ld_sq = 1'b0;
    logic                  upd_armed = 1'b0;
    logic                  upd_fire = 1'b0;
    logic [reg_addr_w-1:0] ld_rd;
    logic [xlen-1:0]       ld_val;
    int                    ld_cnt;
    int                    upd_cnt;
    int                    n_acc = 0;

    always #20 clk = ~clk;

    exu_top #(.bypass_depth(depth)) dut0 (.*);
    exu_checker #(.bypass_depth(depth)) chk0 (.*);

    // Small register numbers so writers collide often
    task automatic new_instr();
        int kind;
        kind = $urandom % 8;
        if (kind == 2 && ld_busy) begin
            kind = 1;                                // One load in flight at most
        end
        pc          = $urandom & 32'hffff_fffc;
        imm         = ($urandom % 16) * 4 - 32;      // Hits pc+4 for branches now and then
        rs1         = 5'($urandom % 8);
        rs2         = 5'($urandom % 8);
        rd          = 5'($urandom % 8);
        alu_op      = alu_op_t'($urandom % 10);
        cmp_op      = cmp_op_t'($urandom % 6);
        gpr_we      = 1'b1;
        is_load     = 1'b0;
        is_store    = 1'b0;
        src1_is_pc  = 1'b0;
        src2_is_imm = (kind != 0);
        is_jump     = 1'b0;
        is_branch   = 1'b0;
        case (kind)
            2: begin
                is_load = 1'b1;
                alu_op  = alu_add;
            end
            3: begin
                is_store = 1'b1;
                gpr_we   = 1'b0;
                alu_op   = alu_add;
            end
            4: begin
                is_branch  = 1'b1;
                gpr_we     = 1'b0;
                src1_is_pc = 1'b1;
                alu_op     = alu_add;
            end
            5: begin
                is_jump    = 1'b1;                   // jal
                src1_is_pc = 1'b1;
                alu_op     = alu_add;
            end
            6: begin
                is_jump = 1'b1;                      // jalr
                alu_op  = alu_add;
            end
            7: begin
                alu_op = alu_pass_b;                 // lui
                imm    = $urandom & 32'hffff_f000;
            end
            default: begin
            end
        endcase
    endtask

    initial begin
        void'($urandom(32'h4bbb));
        rst             = 1'b1;
        idu_valid       = 1'b0;
        lsu_ready       = 1'b0;
        load_data_valid = 1'b0;
        load_data       = '0;
        pc_update       = 1'b0;
        for (int i = 0; i < 32; i++) begin
            rf[i] = (i == 0) ? '0 : $urandom;
        end
        new_instr();
        rs1_data = rf[rs1];
        rs2_data = rf[rs2];
        repeat (8) @(posedge clk);
        #2 rst = 1'b0;

        while (n_acc < n_instr) begin
            //////////////////////////////////////////////////////////////////////
            // Sample where everything is settled
            //////////////////////////////////////////////////////////////////////
            @(negedge clk);
            acc = idu_valid && exu_ready;
            if (exu_valid && gpr_we_out && !is_load_out && rd_out != 0) begin
                rf[rd_out] = res_out;                // Retire
                if (ld_busy && ld_rd == rd_out) begin
                    ld_sq = 1'b1;                    // Younger writer wins
                end
            end
            if (ld_busy) begin
                ld_cnt--;
                if (ld_cnt == 0) begin
                    ld_val = $urandom;
                    if (!ld_sq && ld_rd != 0) begin
                        rf[ld_rd] = ld_val;
                    end
                    ld_fire = 1'b1;
                    ld_busy = 1'b0;
                end
            end
            if (acc && is_load) begin
                ld_busy = 1'b1;
                ld_cnt  = 1 + $urandom % 6;
                ld_rd   = rd;
                ld_sq   = redirect_valid;            // Squashed loads still get a reply
            end
            if (!redirect_valid) begin
                upd_armed = 1'b0;
            end else if (!upd_armed) begin
                upd_armed = 1'b1;
                upd_cnt   = 1 + $urandom % 4;
            end else if (upd_cnt > 0) begin
                upd_cnt--;
                upd_fire = (upd_cnt == 0);
            end
            if (acc) begin
                n_acc++;
            end

            //////////////////////////////////////////////////////////////////////
            // Drive just after the edge
            //////////////////////////////////////////////////////////////////////
            @(posedge clk);
            #2;
            load_data_valid = ld_fire;
            load_data       = ld_fire ? ld_val : $urandom;
            ld_fire         = 1'b0;
            pc_update       = upd_fire;
            upd_fire        = 1'b0;
            lsu_ready       = ($urandom % 5) != 0;
            if (acc || !idu_valid) begin
                idu_valid = ($urandom % 8) != 0;
                new_instr();
            end
            rs1_data = rf[rs1];
            rs2_data = rf[rs2];
        end

        idu_valid = 1'b0;
        repeat (10) @(posedge clk);
        $display("errors: %0d, outputs checked: %0d, accepted: %0d",
                 chk0.errors, chk0.checked, n_acc);
        if (chk0.errors == 0 && chk0.checked > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(n_instr * max_cycles * 40);
        $display("Watchdog expired with %0d of %0d instructions accepted", n_acc, n_instr);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* flist.f */
design/exu_pkg.sv
design/exu_operand_fwd.sv
design/exu_alu.sv
design/exu_redirect.sv
design/exu_result_reg.sv
design/exu_top.sv
test/exu_checker.sv
test/exu_tb.sv

/* Makefile */
TOP := exu_tb

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "TESTS PASSED" sim.log

obj_dir/V$(TOP): flist.f design/*.sv test/*.sv
	verilator --binary --timing -f flist.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only -Wall design/exu_pkg.sv design/exu_operand_fwd.sv \
		design/exu_alu.sv design/exu_redirect.sv design/exu_result_reg.sv \
		design/exu_top.sv --top-module exu_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
